// File: hdl/snn_params.svh
`ifndef SNN_PARAMS_SVH
`define SNN_PARAMS_SVH

// network size
`define SNN_PIXELS      81
`define SNN_OUTPUTS     10
// weight of pixel p for output k sits at p*10+k
`define SNN_WEIGHTS     810
`define SNN_QUEUE_DEPTH 128

// run defaults
`define SNN_DEFAULT_STEPS 100
`define SNN_LFSR_SEED     8'hb8
`define SNN_LFSR_TAPS     8'hb8

// 4 KB word-indexed regions on the bus
`define SNN_IMAGE_BASE  32'h3000_0000
`define SNN_WEIGHT_BASE 32'h3000_1000
`define SNN_COUNT_BASE  32'h3000_3000
`define SNN_CTRL_ADDR   32'h3000_4000
`define SNN_REGION_SIZE 32'h0000_1000

`endif

// File: hdl/snn_bus_pkg.sv
package snn_bus_pkg;

    // one bus cycle as driven by the host
    typedef struct packed {
        logic        stb;
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic       start;
        logic [9:0] steps;
        logic [7:0] vth;
        logic [7:0] beta;
    } ctrl_t;

    typedef enum logic [2:0] {
        REG_NONE,
        REG_IMAGE,
        REG_WEIGHT,
        REG_COUNT,
        REG_CTRL
    } region_e;

    // start at bit 28, steps at [25:16]
    function automatic logic [31:0] ctrl_to_word(ctrl_t c);
        return {3'b000, c.start, 2'b00, c.steps, c.vth, c.beta};
    endfunction

    function automatic ctrl_t word_to_ctrl(logic [31:0] w);
        ctrl_t c;
        c.start = w[28];
        c.steps = w[25:16];
        c.vth   = w[15:8];
        c.beta  = w[7:0];
        return c;
    endfunction

endpackage

// File: hdl/snn_core_pkg.sv
package snn_core_pkg;

    // single write into an 8-bit memory
    typedef struct packed {
        logic       en;
        logic [9:0] idx;
        logic [7:0] data;
    } mem_wr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ENCODE,
        ST_POP,
        ST_LOAD,
        ST_INTEGRATE,
        ST_LEAK,
        ST_FIRE,
        ST_CHECK
    } core_state_e;

    typedef enum logic {
        OP_INTEGRATE,
        OP_LEAK_FIRE
    } neuron_op_e;

    // unsigned add, clamps at 255
    function automatic logic [7:0] sat_add8(logic [7:0] a, logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[8] ? 8'hff : sum[7:0];
    endfunction

endpackage

// File: hdl/snn_bus_slave.sv
`timescale 1ns/1ps
`include "snn_params.svh"

module snn_bus_slave (
    input  logic                  clk,
    input  logic                  rst,
    input  snn_bus_pkg::bus_req_t req_i,
    output logic                  ack_o,
    output logic [31:0]           rdata_o,
    output snn_core_pkg::mem_wr_t image_wr_o,
    output snn_core_pkg::mem_wr_t weight_wr_o,
    output snn_bus_pkg::ctrl_t    ctrl_o,
    input  logic                  run_done_i,
    output logic [3:0]            count_index_o,
    input  logic [7:0]            count_i
);
    import snn_bus_pkg::*;
    import snn_core_pkg::*;

    region_e     region;
    logic [31:0] offset;
    logic [9:0]  word_idx;
    logic        act;
    logic [31:0] rdata_c;
    mem_wr_t     wr_c;
    ctrl_t       ctrl_q;

    // address decode
    always_comb
    begin
        region = REG_NONE;
        offset = '0;
        if (req_i.addr == `SNN_CTRL_ADDR)
        begin
            region = REG_CTRL;
        end
        else if ((req_i.addr - `SNN_IMAGE_BASE) < `SNN_REGION_SIZE)
        begin
            region = REG_IMAGE;
            offset = req_i.addr - `SNN_IMAGE_BASE;
        end
        else if ((req_i.addr - `SNN_WEIGHT_BASE) < `SNN_REGION_SIZE)
        begin
            region = REG_WEIGHT;
            offset = req_i.addr - `SNN_WEIGHT_BASE;
        end
        else if ((req_i.addr - `SNN_COUNT_BASE) < `SNN_REGION_SIZE)
        begin
            region = REG_COUNT;
            offset = req_i.addr - `SNN_COUNT_BASE;
        end
    end

    assign word_idx      = offset[11:2];
    assign count_index_o = word_idx[3:0];

    // a new cycle only when no ack went out just before
    assign act = req_i.stb && !ack_o;

    // memory writes land on the same edge as the ack
    always_comb
    begin
        wr_c.en   = act && req_i.we;
        wr_c.idx  = word_idx;
        wr_c.data = req_i.wdata[7:0];

        image_wr_o     = wr_c;
        image_wr_o.en  = wr_c.en && (region == REG_IMAGE);
        weight_wr_o    = wr_c;
        weight_wr_o.en = wr_c.en && (region == REG_WEIGHT);
    end

    // unmapped reads return 0
    always_comb
    begin
        rdata_c = '0;
        if (act && !req_i.we)
        begin
            case (region)
                REG_COUNT:
                begin
                    if (word_idx < `SNN_OUTPUTS)
                    begin
                        rdata_c = {24'b0, count_i};
                    end
                end
                REG_CTRL: rdata_c = ctrl_to_word(ctrl_q);
                default:  rdata_c = '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ack_o        <= 1'b0;
            ctrl_q.start <= 1'b0;
            ctrl_q.steps <= 10'(`SNN_DEFAULT_STEPS);
            ctrl_q.vth   <= '0;
            ctrl_q.beta  <= '0;
        end
        else
        begin
            ack_o <= act;
            if (act && req_i.we && region == REG_CTRL)
            begin
                ctrl_q <= word_to_ctrl(req_i.wdata);
            end
            // run finished, drop start
            if (run_done_i)
            begin
                ctrl_q.start <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        rdata_o <= rdata_c;
    end

    assign ctrl_o = ctrl_q;

    a_single_ack: assert property (@(posedge clk) disable iff (rst) ack_o |=> !ack_o);

endmodule

// File: hdl/spike_encoder.sv
`timescale 1ns/1ps
`include "snn_params.svh"

module spike_encoder (
    input  logic                  clk,
    input  logic                  rst,
    input  snn_core_pkg::mem_wr_t image_wr_i,
    input  logic                  encode_start_i,
    output logic                  encode_done_o,
    output logic                  spike_valid_o,
    output logic [6:0]            spike_pixel_o,
    input  logic                  spike_pop_i
);
    localparam int QW = $clog2(`SNN_QUEUE_DEPTH);
    localparam logic [6:0] LAST_PIX = 7'(`SNN_PIXELS - 1);

    logic [7:0]    pixel_mem [`SNN_PIXELS];
    logic [7:0]    pixel_q;
    logic [6:0]    pix_idx;
    logic          busy;
    logic          cmp_phase;
    logic [7:0]    lfsr;
    logic [7:0]    lfsr_next;
    logic          push;

    logic [6:0]    queue [`SNN_QUEUE_DEPTH];
    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [QW:0]   count;
    logic          full;

    always_ff @(posedge clk)
    begin
        if (image_wr_i.en && image_wr_i.idx < `SNN_PIXELS)
        begin
            pixel_mem[image_wr_i.idx[6:0]] <= image_wr_i.data;
        end
        pixel_q <= pixel_mem[pix_idx];
    end

    // galois form, never reaches zero
    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ `SNN_LFSR_TAPS) : (lfsr >> 1);

    // read phase then compare phase for each pixel
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy          <= 1'b0;
            cmp_phase     <= 1'b0;
            pix_idx       <= '0;
            encode_done_o <= 1'b0;
            lfsr          <= `SNN_LFSR_SEED;
        end
        else
        begin
            encode_done_o <= 1'b0;
            if (encode_start_i)
            begin
                busy      <= 1'b1;
                cmp_phase <= 1'b0;
                pix_idx   <= '0;
            end
            else if (busy)
            begin
                cmp_phase <= !cmp_phase;
                if (cmp_phase)
                begin
                    lfsr <= lfsr_next;
                    if (pix_idx == LAST_PIX)
                    begin
                        busy          <= 1'b0;
                        encode_done_o <= 1'b1;
                    end
                    else
                    begin
                        pix_idx <= pix_idx + 7'd1;
                    end
                end
            end
        end
    end

    assign push = busy && cmp_phase && (lfsr <= pixel_q);

    // spike queue
    assign full          = (count == (QW+1)'(`SNN_QUEUE_DEPTH));
    assign spike_valid_o = (count != '0);
    assign spike_pixel_o = queue[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            queue[wr_ptr] <= pix_idx;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (spike_pop_i)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, spike_pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full));
    a_no_underrun: assert property (@(posedge clk) disable iff (rst)
        spike_pop_i |-> spike_valid_o);

endmodule

// File: hdl/snn_core.sv
`timescale 1ns/1ps
`include "snn_params.svh"

module snn_core (
    input  logic                  clk,
    input  logic                  rst,
    input  snn_bus_pkg::ctrl_t    ctrl_i,
    input  snn_core_pkg::mem_wr_t weight_wr_i,
    output logic                  encode_start_o,
    input  logic                  encode_done_i,
    input  logic                  spike_valid_i,
    input  logic [6:0]            spike_pixel_i,
    output logic                  spike_pop_o,
    output logic                  run_start_o,
    output logic                  fire_o,
    output logic [3:0]            fire_index_o,
    output logic                  run_done_o
);
    import snn_core_pkg::*;

    localparam logic [3:0] LAST_OUT = 4'(`SNN_OUTPUTS - 1);

    core_state_e state;
    logic [9:0]  step_cnt;
    logic        last_step;
    logic [3:0]  out_idx;
    logic [6:0]  pixel_q;

    logic [7:0]  weight_mem [`SNN_WEIGHTS];
    logic [9:0]  weight_addr;
    logic [7:0]  weight_q;

    logic [7:0]  vmem [`SNN_OUTPUTS];
    neuron_op_e  op;
    logic [15:0] leak_prod;
    logic [7:0]  nv_c;
    logic        spike_c;
    // write-back stage
    logic [7:0]  nv_q;
    logic        spike_q;
    logic        wb_en;
    logic [3:0]  wb_idx;

    assign weight_addr = 10'(pixel_q) * 10'd10 + 10'(out_idx);

    always_ff @(posedge clk)
    begin
        if (weight_wr_i.en && weight_wr_i.idx < `SNN_WEIGHTS)
        begin
            weight_mem[weight_wr_i.idx] <= weight_wr_i.data;
        end
        if (state == ST_LOAD)
        begin
            weight_q <= weight_mem[weight_addr];
        end
    end

    // neuron arithmetic
    assign op        = (state == ST_LEAK) ? OP_LEAK_FIRE : OP_INTEGRATE;
    assign leak_prod = vmem[out_idx] * ctrl_i.beta;

    always_comb
    begin
        case (op)
            OP_LEAK_FIRE:
            begin
                spike_c = (vmem[out_idx] >= ctrl_i.vth);
                nv_c    = spike_c ? 8'd0 : leak_prod[15:8];
            end
            default:
            begin
                spike_c = 1'b0;
                nv_c    = sat_add8(vmem[out_idx], weight_q);
            end
        endcase
    end

    assign last_step      = ({1'b0, step_cnt} + 11'd1) >= {1'b0, ctrl_i.steps};
    assign run_start_o    = (state == ST_IDLE) && ctrl_i.start;
    assign encode_start_o = run_start_o || (state == ST_CHECK && !last_step);
    assign spike_pop_o    = (state == ST_POP) && spike_valid_i;
    assign fire_o         = (state == ST_FIRE) && spike_q;
    assign fire_index_o   = out_idx;
    assign run_done_o     = (state == ST_CHECK) && last_step;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ST_IDLE;
            step_cnt <= '0;
            out_idx  <= '0;
            wb_en    <= 1'b0;
        end
        else
        begin
            wb_en <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    step_cnt <= '0;
                    if (ctrl_i.start)
                    begin
                        state <= ST_ENCODE;
                    end
                end
                ST_ENCODE:
                begin
                    if (encode_done_i)
                    begin
                        state <= ST_POP;
                    end
                end
                ST_POP:
                begin
                    out_idx <= '0;
                    state   <= spike_valid_i ? ST_LOAD : ST_LEAK;
                end
                ST_LOAD: state <= ST_INTEGRATE;
                ST_INTEGRATE:
                begin
                    wb_en <= 1'b1;
                    if (out_idx == LAST_OUT)
                    begin
                        state <= ST_POP;
                    end
                    else
                    begin
                        out_idx <= out_idx + 4'd1;
                        state   <= ST_LOAD;
                    end
                end
                ST_LEAK:
                begin
                    wb_en <= 1'b1;
                    state <= ST_FIRE;
                end
                ST_FIRE:
                begin
                    if (out_idx == LAST_OUT)
                    begin
                        state <= ST_CHECK;
                    end
                    else
                    begin
                        out_idx <= out_idx + 4'd1;
                        state   <= ST_LEAK;
                    end
                end
                default:
                begin
                    // check end of timestep
                    step_cnt <= step_cnt + 10'd1;
                    state    <= last_step ? ST_IDLE : ST_ENCODE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (spike_pop_o)
        begin
            pixel_q <= spike_pixel_i;
        end
        if (state == ST_INTEGRATE || state == ST_LEAK)
        begin
            nv_q    <= nv_c;
            spike_q <= spike_c;
            wb_idx  <= out_idx;
        end
    end

    // membranes start from zero on every run
    always_ff @(posedge clk)
    begin
        if (run_start_o)
        begin
            for (int i = 0; i < `SNN_OUTPUTS; i++)
            begin
                vmem[i] <= '0;
            end
        end
        else if (wb_en)
        begin
            vmem[wb_idx] <= nv_q;
        end
    end

    a_out_range: assert property (@(posedge clk) disable iff (rst)
        out_idx < 4'(`SNN_OUTPUTS));

endmodule

// File: hdl/spike_counter_bank.sv
`timescale 1ns/1ps
`include "snn_params.svh"

module spike_counter_bank (
    input  logic       clk,
    input  logic       rst,
    input  logic       run_start_i,
    input  logic       fire_i,
    input  logic [3:0] fire_index_i,
    input  logic       run_done_i,
    input  logic [3:0] count_index_i,
    output logic [7:0] count_o,
    output logic       irq_o
);
    import snn_core_pkg::*;

    logic [7:0] counts [`SNN_OUTPUTS];

    always_ff @(posedge clk)
    begin
        if (rst || run_start_i)
        begin
            for (int i = 0; i < `SNN_OUTPUTS; i++)
            begin
                counts[i] <= '0;
            end
            irq_o <= 1'b0;
        end
        else
        begin
            if (fire_i && fire_index_i < `SNN_OUTPUTS)
            begin
                counts[fire_index_i] <= sat_add8(counts[fire_index_i], 8'd1);
            end
            if (run_done_i)
            begin
                irq_o <= 1'b1;
            end
        end
    end

    // out of range index reads as zero
    assign count_o = (count_index_i < `SNN_OUTPUTS) ? counts[count_index_i] : 8'd0;

endmodule

// File: hdl/snn_top.sv
`timescale 1ns/1ps

module snn_top (
    input  logic                  clk,
    input  logic                  rst,
    input  snn_bus_pkg::bus_req_t req_i,
    output logic                  ack_o,
    output logic [31:0]           rdata_o,
    output logic                  irq_o
);
    import snn_bus_pkg::*;
    import snn_core_pkg::*;

    ctrl_t      ctrl;
    mem_wr_t    image_wr;
    mem_wr_t    weight_wr;
    logic [3:0] count_index;
    logic [7:0] count;

    logic       encode_start;
    logic       encode_done;
    logic       spike_valid;
    logic [6:0] spike_pixel;
    logic       spike_pop;

    logic       run_start;
    logic       fire;
    logic [3:0] fire_index;
    logic       run_done;

    snn_bus_slave u_bus (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .rdata_o       (rdata_o),
        .image_wr_o    (image_wr),
        .weight_wr_o   (weight_wr),
        .ctrl_o        (ctrl),
        .run_done_i    (run_done),
        .count_index_o (count_index),
        .count_i       (count)
    );

    spike_encoder u_encoder (
        .clk            (clk),
        .rst            (rst),
        .image_wr_i     (image_wr),
        .encode_start_i (encode_start),
        .encode_done_o  (encode_done),
        .spike_valid_o  (spike_valid),
        .spike_pixel_o  (spike_pixel),
        .spike_pop_i    (spike_pop)
    );

    snn_core u_core (
        .clk            (clk),
        .rst            (rst),
        .ctrl_i         (ctrl),
        .weight_wr_i    (weight_wr),
        .encode_start_o (encode_start),
        .encode_done_i  (encode_done),
        .spike_valid_i  (spike_valid),
        .spike_pixel_i  (spike_pixel),
        .spike_pop_o    (spike_pop),
        .run_start_o    (run_start),
        .fire_o         (fire),
        .fire_index_o   (fire_index),
        .run_done_o     (run_done)
    );

    spike_counter_bank u_counts (
        .clk           (clk),
        .rst           (rst),
        .run_start_i   (run_start),
        .fire_i        (fire),
        .fire_index_i  (fire_index),
        .run_done_i    (run_done),
        .count_index_i (count_index),
        .count_o       (count),
        .irq_o         (irq_o)
    );

endmodule

// File: test/tb_snn.sv
`timescale 1ns/1ps
`include "snn_params.svh"

module tb_snn;
    import snn_bus_pkg::*;

    localparam int ACK_TIMEOUT = 20;
    localparam int IRQ_TIMEOUT = 200000;

    logic        clk;
    logic        rst;
    bus_req_t    req;
    logic        ack;
    logic [31:0] rdata;
    logic        irq;

    // host-side copies of what gets loaded, plus expected counts
    logic [7:0]  image_buf [`SNN_PIXELS];
    logic [7:0]  weight_buf [`SNN_WEIGHTS];
    logic [7:0]  exp_counts [`SNN_OUTPUTS];
    logic [31:0] lfsr_state;

    snn_top DUT (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req),
        .ack_o   (ack),
        .rdata_o (rdata),
        .irq_o   (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_value_error(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic abort_run(input string why);
        $display("Error at %0d ns: %s", $time, why);
        stop_run();
    endtask

    task automatic check_count(input string what, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            report_value_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_ctrl(input string what, input ctrl_t got, input ctrl_t exp);
        if (got !== exp)
        begin
            report_value_error($sformatf("%s: got start %0b steps %0d vth %0d beta %0d, %s",
                what, got.start, got.steps, got.vth, got.beta,
                $sformatf("expected start %0b steps %0d vth %0d beta %0d",
                    exp.start, exp.steps, exp.vth, exp.beta)));
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            report_value_error($sformatf("%s: got %0b, expected %0b", what, got, exp));
        end
    endtask

    // 32-bit galois, right shifting
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int nbits, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    // control word layout: start [28], steps [25:16], vth [15:8], beta [7:0]
    function automatic logic [31:0] pack_ctrl(input ctrl_t c);
        return {3'b000, c.start, 2'b00, c.steps, c.vth, c.beta};
    endfunction

    function automatic ctrl_t unpack_ctrl(input logic [31:0] w);
        ctrl_t c;
        c.start = w[28];
        c.steps = w[25:16];
        c.vth   = w[15:8];
        c.beta  = w[7:0];
        return c;
    endfunction

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        req.stb   = 1'b1;
        req.we    = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        @(negedge clk);
        while (!ack)
        begin
            if (waited >= ACK_TIMEOUT)
            begin
                abort_run($sformatf("no ack for write to %h", addr));
            end
            @(negedge clk);
            waited++;
        end
        req.stb = 1'b0;
        req.we  = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clk);
        req.stb  = 1'b1;
        req.we   = 1'b0;
        req.addr = addr;
        @(negedge clk);
        while (!ack)
        begin
            if (waited >= ACK_TIMEOUT)
            begin
                abort_run($sformatf("no ack for read of %h", addr));
            end
            @(negedge clk);
            waited++;
        end
        data    = rdata;
        req.stb = 1'b0;
    endtask

    task automatic read_ctrl(output ctrl_t c);
        logic [31:0] data;
        bus_read(`SNN_CTRL_ADDR, data);
        c = unpack_ctrl(data);
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!irq)
        begin
            if (waited >= IRQ_TIMEOUT)
            begin
                abort_run("irq never rose at the end of the run");
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic clear_buffers();
        for (int p = 0; p < `SNN_PIXELS; p++)
        begin
            image_buf[p] = 8'd0;
        end
        for (int i = 0; i < `SNN_WEIGHTS; i++)
        begin
            weight_buf[i] = 8'd0;
        end
    endtask

    task automatic load_memories();
        for (int p = 0; p < `SNN_PIXELS; p++)
        begin
            bus_write(`SNN_IMAGE_BASE + 32'(4 * p), {24'd0, image_buf[p]});
        end
        for (int i = 0; i < `SNN_WEIGHTS; i++)
        begin
            bus_write(`SNN_WEIGHT_BASE + 32'(4 * i), {24'd0, weight_buf[i]});
        end
    endtask

    // only 0 and 255 pixels, so every spike is known in advance
    task automatic predict_counts(input int vth, input int beta, input int steps);
        int v [`SNN_OUTPUTS];
        int cnt [`SNN_OUTPUTS];
        for (int k = 0; k < `SNN_OUTPUTS; k++)
        begin
            v[k]   = 0;
            cnt[k] = 0;
        end
        for (int p = 0; p < `SNN_PIXELS; p++)
        begin
            if (image_buf[p] != 8'd0 && image_buf[p] != 8'd255)
            begin
                abort_run("reference model given a pixel other than 0 or 255");
            end
        end
        for (int t = 0; t < steps; t++)
        begin
            for (int p = 0; p < `SNN_PIXELS; p++)
            begin
                if (image_buf[p] == 8'd255)
                begin
                    for (int k = 0; k < `SNN_OUTPUTS; k++)
                    begin
                        v[k] = v[k] + int'(weight_buf[p * 10 + k]);
                        if (v[k] > 255)
                        begin
                            v[k] = 255;
                        end
                    end
                end
            end
            for (int k = 0; k < `SNN_OUTPUTS; k++)
            begin
                if (v[k] >= vth)
                begin
                    cnt[k] = (cnt[k] < 255) ? cnt[k] + 1 : 255;
                    v[k]   = 0;
                end
                else
                begin
                    v[k] = (v[k] * beta) >> 8;
                end
            end
        end
        for (int k = 0; k < `SNN_OUTPUTS; k++)
        begin
            exp_counts[k] = 8'(cnt[k]);
        end
    endtask

    task automatic check_all_counts(input string what);
        logic [31:0] data;
        for (int k = 0; k < `SNN_OUTPUTS; k++)
        begin
            bus_read(`SNN_COUNT_BASE + 32'(4 * k), data);
            check_count($sformatf("%s, count %0d", what, k), data[7:0], exp_counts[k]);
        end
    endtask

    // start, wait for the end, then check counts and the cleared start bit
    task automatic run_and_check(input string what, input ctrl_t c);
        ctrl_t got;
        ctrl_t exp;
        c.start = 1'b1;
        bus_write(`SNN_CTRL_ADDR, pack_ctrl(c));
        wait_irq();
        check_all_counts(what);
        exp       = c;
        exp.start = 1'b0;
        read_ctrl(got);
        check_ctrl({what, ", control after run"}, got, exp);
    endtask

    task automatic test_ctrl_defaults();
        ctrl_t got;
        ctrl_t exp;
        check_flag("ack after reset", ack, 1'b0);
        check_flag("irq after reset", irq, 1'b0);
        exp = '{start: 1'b0, steps: 10'd100, vth: 8'd0, beta: 8'd0};
        read_ctrl(got);
        check_ctrl("control defaults", got, exp);
        for (int k = 0; k < `SNN_OUTPUTS; k++)
        begin
            exp_counts[k] = 8'd0;
        end
        check_all_counts("counts after reset");
        exp = '{start: 1'b0, steps: 10'd37, vth: 8'h5a, beta: 8'hc3};
        bus_write(`SNN_CTRL_ADDR, pack_ctrl(exp));
        read_ctrl(got);
        check_ctrl("control readback", got, exp);
    endtask

    task automatic test_blank_image();
        clear_buffers();
        load_memories();
        for (int k = 0; k < `SNN_OUTPUTS; k++)
        begin
            exp_counts[k] = 8'd0;
        end
        run_and_check("blank image", '{start: 1'b0, steps: 10'd5, vth: 8'd10, beta: 8'd128});
    endtask

    task automatic test_single_path();
        clear_buffers();
        image_buf[40]            = 8'd255;
        weight_buf[40 * 10 + 3]  = 8'd200;
        load_memories();
        for (int k = 0; k < `SNN_OUTPUTS; k++)
        begin
            exp_counts[k] = (k == 3) ? 8'd7 : 8'd0;
        end
        run_and_check("single path", '{start: 1'b0, steps: 10'd7, vth: 8'd150, beta: 8'd128});
    endtask

    task automatic test_leak_accumulation();
        clear_buffers();
        image_buf[5]  = 8'd255;
        image_buf[17] = 8'd255;
        image_buf[40] = 8'd255;
        image_buf[63] = 8'd255;
        for (int i = 0; i < `SNN_WEIGHTS; i++)
        begin
            draw_bits(6, weight_buf[i]);
        end
        load_memories();
        predict_counts(100, 192, 12);
        run_and_check("leak accumulation",
            '{start: 1'b0, steps: 10'd12, vth: 8'd100, beta: 8'd192});
    endtask

    task automatic test_saturation_rerun();
        ctrl_t       c;
        logic [7:0]  w;
        logic [31:0] data;
        int          pix [4];
        clear_buffers();
        pix = '{2, 30, 50, 77};
        for (int i = 0; i < `SNN_WEIGHTS; i++)
        begin
            draw_bits(8, weight_buf[i]);
        end
        // even outputs overflow the potential, odd ones build up under leak
        foreach (pix[j])
        begin
            image_buf[pix[j]] = 8'd255;
            for (int k = 0; k < `SNN_OUTPUTS; k++)
            begin
                if (k % 2 == 0)
                begin
                    draw_bits(7, w);
                    weight_buf[pix[j] * 10 + k] = 8'h80 | w;
                end
                else
                begin
                    draw_bits(5, weight_buf[pix[j] * 10 + k]);
                end
            end
        end
        load_memories();
        predict_counts(250, 230, 20);
        c = '{start: 1'b0, steps: 10'd20, vth: 8'd250, beta: 8'd230};
        run_and_check("saturation", c);
        check_flag("irq before rerun", irq, 1'b1);
        c.start = 1'b1;
        bus_write(`SNN_CTRL_ADDR, pack_ctrl(c));
        @(negedge clk);
        check_flag("irq after second start", irq, 1'b0);
        bus_read(`SNN_COUNT_BASE, data);
        check_count("count 0 after second start", data[7:0], 8'd0);
        wait_irq();
        check_all_counts("saturation rerun");
    endtask

    initial
    begin
        rst        = 1'b1;
        req        = '0;
        lfsr_state = 32'hf2ff8490;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_ctrl_defaults();
        test_blank_image();
        test_single_path();
        test_leak_accumulation();
        test_saturation_rerun();

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+hdl
hdl/snn_bus_pkg.sv
hdl/snn_core_pkg.sv
hdl/snn_bus_slave.sv
hdl/spike_encoder.sv
hdl/snn_core.sv
hdl/spike_counter_bank.sv
hdl/snn_top.sv
test/tb_snn.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_snn -o tb_snn_sim

./obj_dir/tb_snn_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "run ended without a result line"
    exit 1
fi
exit 0
